//--- design/fb_axi_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_consts.svh"

interface fb_axi_if #(
  parameter int ADDR_BITS = `FB_ADDR_BITS,
  parameter int DATA_BITS = `FB_DATA_BITS
);
  localparam int STRB_BITS = (DATA_BITS + 7) / 8;

  // write address channel
  logic [ADDR_BITS-1:0] awaddr;
  logic                 awvalid;
  logic                 awready;

  // write data channel
  logic [DATA_BITS-1:0] wdata;
  logic [STRB_BITS-1:0] wstrb;
  logic                 wvalid;
  logic                 wready;

  // write response channel
  logic                 bvalid;
  logic                 bready;
  logic [1:0]           bresp;

  modport master (
    output awaddr,
    output awvalid,
    input  awready,
    output wdata,
    output wstrb,
    output wvalid,
    input  wready,
    input  bvalid,
    output bready,
    input  bresp
  );

  modport slave (
    input  awaddr,
    input  awvalid,
    output awready,
    input  wdata,
    input  wstrb,
    input  wvalid,
    output wready,
    output bvalid,
    input  bready,
    output bresp
  );

endinterface

`default_nettype wire

//--- design/fb_axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_consts.svh"

module fb_axi_sram (
  input  wire                   clk,
  input  wire                   reset,

  // holds both readies low, memory busy elsewhere
  input  wire                   mem_stall,

  fb_axi_if.slave               axi,

  // readback port
  input  wire fb_pkg::fb_addr_t rd_addr,
  output fb_pkg::fb_data_t      rd_data
);
  import fb_pkg::*;

  localparam int         DEPTH     = `FB_WIDTH * `FB_HEIGHT;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  fb_data_t mem [DEPTH];

  logic resp_pending;
  logic accept_ok;
  logic write_fire;

  // a response the master has not taken yet blocks the next write
  assign resp_pending = axi.bvalid & ~axi.bready;
  assign accept_ok    = ~mem_stall & ~resp_pending;

  // address and data readies always move together
  assign axi.awready = accept_ok;
  assign axi.wready  = accept_ok;

  assign write_fire = axi.awvalid & axi.awready & axi.wvalid & axi.wready;

  // every write succeeds
  assign axi.bresp = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (reset) begin
      axi.bvalid <= 1'b0;
    end else if (write_fire) begin
      axi.bvalid <= 1'b1;
    end else if (axi.bready) begin
      axi.bvalid <= 1'b0;
    end
  end

  // byte lane writes
  always_ff @(posedge clk) begin
    if (write_fire) begin
      for (int b = 0; b < `FB_STRB_BITS; b++) begin
        if (axi.wstrb[b]) begin
          mem[axi.awaddr][b*8 +: 8] <= axi.wdata[b*8 +: 8];
        end
      end
    end
  end

  // one clock read latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- design/fb_consts.svh
`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// frame geometry in pixels
`define FB_WIDTH 64
`define FB_HEIGHT 64

// wide enough that a size of 64 still fits
`define FB_COORD_BITS 7

// one word per pixel, 64 x 64 words
`define FB_ADDR_BITS 12

// color sits in the top bits of a memory word
`define FB_PIXEL_BITS 12
`define FB_DATA_BITS 16

// byte lanes of a memory word
`define FB_STRB_BITS 2

`endif

//--- design/fb_fill_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_consts.svh"

module fb_fill_top (
  input  wire                   clk,
  input  wire                   reset,

  // fill command, taken while busy is low
  input  wire                   cmd_valid,
  input  wire fb_pkg::coord_t   cmd_x,
  input  wire fb_pkg::coord_t   cmd_y,
  input  wire fb_pkg::coord_t   cmd_w,
  input  wire fb_pkg::coord_t   cmd_h,
  input  wire fb_pkg::color_t   cmd_color,
  output logic                  busy,

  input  wire                   mem_stall,

  // frame readback
  input  wire fb_pkg::fb_addr_t rd_addr,
  output fb_pkg::fb_data_t      rd_data
);
  import fb_pkg::*;

  logic     pix_valid;
  logic     pix_ready;
  fb_addr_t pix_addr;
  color_t   pix_color;
  logic     filling;
  logic     writing;

  fb_axi_if #(
    .ADDR_BITS(`FB_ADDR_BITS),
    .DATA_BITS(`FB_DATA_BITS)
  ) axi_bus ();

  rect_filler u_filler (
    .clk      (clk),
    .reset    (reset),
    .cmd_valid(cmd_valid),
    .cmd_x    (cmd_x),
    .cmd_y    (cmd_y),
    .cmd_w    (cmd_w),
    .cmd_h    (cmd_h),
    .cmd_color(cmd_color),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready),
    .pix_addr (pix_addr),
    .pix_color(pix_color),
    .filling  (filling)
  );

  fb_writer #(
    .PIXEL_BITS(`FB_PIXEL_BITS),
    .ADDR_BITS (`FB_ADDR_BITS),
    .DATA_BITS (`FB_DATA_BITS)
  ) u_writer (
    .clk      (clk),
    .reset    (reset),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready),
    .pix_addr (pix_addr),
    .pix_color(pix_color),
    .writing  (writing),
    .axi      (axi_bus.master)
  );

  fb_axi_sram u_sram (
    .clk      (clk),
    .reset    (reset),
    .mem_stall(mem_stall),
    .axi      (axi_bus.slave),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  // filler hands over to the writer without a gap
  assign busy = filling | writing;

endmodule

`default_nettype wire

//--- design/fb_pkg.sv
`default_nettype none

`include "fb_consts.svh"

package fb_pkg;

  // x, y, width or height
  typedef logic [`FB_COORD_BITS-1:0] coord_t;

  // word address, y * frame width + x
  typedef logic [`FB_ADDR_BITS-1:0] fb_addr_t;

  // 12-bit pixel color
  typedef logic [`FB_PIXEL_BITS-1:0] color_t;

  // memory word, color left-justified with zero padding below
  typedef logic [`FB_DATA_BITS-1:0] fb_data_t;

endpackage

`default_nettype wire

//--- design/fb_writer.sv
`timescale 1ns/1ps
`default_nettype none

module fb_writer #(
  parameter int PIXEL_BITS = 12,
  parameter int ADDR_BITS  = 12,
  parameter int DATA_BITS  = 16
) (
  input  wire                  clk,
  input  wire                  reset,

  // pixel stream
  input  wire                  pix_valid,
  output logic                 pix_ready,
  input  wire [ADDR_BITS-1:0]  pix_addr,
  input  wire [PIXEL_BITS-1:0] pix_color,

  output logic                 writing,

  // frame buffer memory, we are the master
  fb_axi_if.master             axi
);
  localparam int STRB_BITS = (DATA_BITS + 7) / 8;
  localparam int PAD_BITS  = DATA_BITS - PIXEL_BITS;

  typedef enum logic {
    IDLE,
    WRITING
  } state_t;

  state_t state;
  state_t next_state;
  logic   write_start;
  logic   aw_fire;
  logic   w_fire;
  logic   write_done;

  assign aw_fire = axi.awvalid & axi.awready;
  assign w_fire  = axi.wvalid & axi.wready;

  // address and data have to land on the same cycle
  assign write_done = aw_fire & w_fire;

  always_comb begin
    next_state  = state;
    write_start = 1'b0;

    case (state)
      IDLE: begin
        if (pix_valid) begin
          write_start = 1'b1;
          next_state  = WRITING;
        end
      end

      WRITING: begin
        if (write_done) begin
          if (pix_valid) begin
            // chain straight into the next pixel
            write_start = 1'b1;
            next_state  = WRITING;
          end else begin
            next_state = IDLE;
          end
        end
      end

      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // a pixel is taken exactly when a new write begins
  assign pix_ready = write_start;
  assign writing   = (state == WRITING);

  always_ff @(posedge clk) begin
    if (reset) begin
      axi.awvalid <= 1'b0;
      axi.wvalid  <= 1'b0;
      axi.bready  <= 1'b1;
    end else begin
      // responses are always welcome
      axi.bready <= 1'b1;

      if (write_start) begin
        axi.awvalid <= 1'b1;
        axi.wvalid  <= 1'b1;
      end else begin
        if (aw_fire) begin
          axi.awvalid <= 1'b0;
        end
        if (w_fire) begin
          axi.wvalid <= 1'b0;
        end
      end
    end
  end

  // payload captured at the start of each write
  always_ff @(posedge clk) begin
    if (write_start) begin
      axi.awaddr <= pix_addr;
      axi.wdata  <= {pix_color, {PAD_BITS{1'b0}}};
    end
  end

  // full words only
  assign axi.wstrb = {STRB_BITS{1'b1}};

endmodule

`default_nettype wire

//--- design/rect_filler.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_consts.svh"

module rect_filler (
  input  wire                 clk,
  input  wire                 reset,

  // fill command
  input  wire                 cmd_valid,
  input  wire fb_pkg::coord_t cmd_x,
  input  wire fb_pkg::coord_t cmd_y,
  input  wire fb_pkg::coord_t cmd_w,
  input  wire fb_pkg::coord_t cmd_h,
  input  wire fb_pkg::color_t cmd_color,

  // pixel stream toward the writer
  output logic                pix_valid,
  input  wire                 pix_ready,
  output fb_pkg::fb_addr_t    pix_addr,
  output fb_pkg::color_t      pix_color,

  output logic                filling
);
  import fb_pkg::*;

  // one spare bit so that x + w cannot wrap
  logic [`FB_COORD_BITS:0] x_end;
  logic [`FB_COORD_BITS:0] y_end;
  coord_t                  clip_w;
  coord_t                  clip_h;
  logic                    empty;
  logic                    cmd_take;
  logic                    pix_take;
  logic                    last_pix;

  // walk state
  coord_t                  row_w;
  coord_t                  col_left;
  coord_t                  row_left;
  fb_addr_t                row_skip;

  assign cmd_take = cmd_valid & ~filling;
  assign pix_take = pix_valid & pix_ready;
  assign last_pix = (col_left == '0) && (row_left == '0);

  // clip right and bottom edges to the frame
  always_comb begin
    x_end = {1'b0, cmd_x} + {1'b0, cmd_w};
    y_end = {1'b0, cmd_y} + {1'b0, cmd_h};

    if (x_end > `FB_WIDTH) begin
      clip_w = coord_t'(`FB_WIDTH - cmd_x);
    end else begin
      clip_w = cmd_w;
    end

    if (y_end > `FB_HEIGHT) begin
      clip_h = coord_t'(`FB_HEIGHT - cmd_y);
    end else begin
      clip_h = cmd_h;
    end

    // start off the frame, or zero size
    empty = (cmd_x >= `FB_WIDTH) || (cmd_y >= `FB_HEIGHT) ||
            (cmd_w == '0) || (cmd_h == '0);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      filling   <= 1'b0;
      pix_valid <= 1'b0;
    end else if (cmd_take) begin
      filling   <= 1'b1;
      pix_valid <= ~empty;
    end else if (filling && !pix_valid) begin
      // nothing left after clipping
      filling <= 1'b0;
    end else if (pix_take && last_pix) begin
      filling   <= 1'b0;
      pix_valid <= 1'b0;
    end
  end

  // address and color only move on a taken pixel, so they hold under stall
  always_ff @(posedge clk) begin
    if (cmd_take) begin
      pix_addr  <= fb_addr_t'(cmd_y) * fb_addr_t'(`FB_WIDTH) + fb_addr_t'(cmd_x);
      pix_color <= cmd_color;
      row_w     <= clip_w;
      col_left  <= clip_w - 1'b1;
      row_left  <= clip_h - 1'b1;
      row_skip  <= fb_addr_t'(`FB_WIDTH) - fb_addr_t'(clip_w);
    end else if (pix_take) begin
      if (col_left != '0) begin
        col_left <= col_left - 1'b1;
        pix_addr <= pix_addr + 1'b1;
      end else if (row_left != '0) begin
        // wrap to the first column of the next row
        row_left <= row_left - 1'b1;
        col_left <= row_w - 1'b1;
        pix_addr <= pix_addr + row_skip + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/fb_pkg.sv
design/fb_axi_if.sv
design/rect_filler.sv
design/fb_writer.sv
design/fb_axi_sram.sv
design/fb_fill_top.sv
tests/fb_fill_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fill testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module fb_fill_tb \
  -f filelist.f \
  -Mdir obj_dir \
  -o fb_fill_sim

./obj_dir/fb_fill_sim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation FAILED, see sim.log"
  exit 1
fi
echo "simulation passed"

//--- tests/fb_fill_patterns.txt
# fill  x  y  w  h  color(hex)  stall density in sixteenths
# check  word address(hex)  expected memory word(hex)
fill 0 0 64 64 000 0
check 000 0000
check fff 0000
fill 5 7 1 1 abc 0
check 1c5 abc0
check 1c4 0000
check 1c6 0000
fill 10 20 8 5 123 8
check 50a 1230
check 611 1230
check 612 0000
fill 60 30 10 3 5a5 14
check 7bf 5a50
check 7c0 0000
fill 62 62 5 5 f0f 8
check fff f0f0
fill 64 0 4 4 777 0
fill 0 70 4 4 777 8
fill 3 3 0 5 eee 0
check 000 0000
fill 12 22 10 10 0f0 14
check 58c 0f00
check 50c 1230
fill 0 40 64 8 3c3 14
check a00 3c30
check c00 0000

//--- tests/fb_fill_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_consts.svh"

module fb_fill_tb;
  import fb_pkg::*;

  localparam int FRAME_WORDS = `FB_WIDTH * `FB_HEIGHT;

  // one line of the pattern file
  typedef struct packed {
    int is_fill;
    int x;
    int y;
    int w;
    int h;
    int color;
    int density;
    int addr;
    int word;
  } step_t;

  logic     clk;
  logic     reset;
  logic     cmd_valid;
  coord_t   cmd_x;
  coord_t   cmd_y;
  coord_t   cmd_w;
  coord_t   cmd_h;
  color_t   cmd_color;
  logic     busy;
  logic     mem_stall;
  fb_addr_t rd_addr;
  fb_data_t rd_data;

  fb_data_t frame_model [FRAME_WORDS];
  step_t    steps [$];
  int       stall_density;
  int       write_total = 0;
  int       error_count;
  int       check_count;
  int       budget_cycles;

  fb_fill_top dut (
    .clk      (clk),
    .reset    (reset),
    .cmd_valid(cmd_valid),
    .cmd_x    (cmd_x),
    .cmd_y    (cmd_y),
    .cmd_w    (cmd_w),
    .cmd_h    (cmd_h),
    .cmd_color(cmd_color),
    .busy     (busy),
    .mem_stall(mem_stall),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    // taps 32, 22, 2, 1
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // four fresh bits per cycle against the density
  initial begin
    logic [31:0] lfsr_state;
    logic [3:0]  draw;
    lfsr_state = 32'h1e26;
    mem_stall  = 1'b0;
    forever begin
      @(posedge clk);
      #10;
      for (int i = 0; i < 4; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        draw       = {draw[2:0], lfsr_state[0]};
      end
      mem_stall = (int'(draw) < stall_density);
    end
  end

  // joint address and data transfers, taken mid-cycle
  always @(negedge clk) begin
    if (dut.axi_bus.awvalid && dut.axi_bus.awready &&
        dut.axi_bus.wvalid && dut.axi_bus.wready) begin
      write_total = write_total + 1;
    end
  end

  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk);
    $display("run did not finish within %0d cycles, a fill or readback hung", budget_cycles);
    $display("checks: %0d, errors: %0d", check_count, error_count + 1);
    $display("Something failed");
    $finish;
  end

  function automatic int clipped_span(input int start, input int size, input int limit);
    if (start >= limit) begin
      return 0;
    end
    if (start + size > limit) begin
      return limit - start;
    end
    return size;
  endfunction

  // color sits in the top 12 bits, low nibble zero
  function automatic fb_data_t color_word(input int color);
    return fb_data_t'(color[11:0]) << 4;
  endfunction

  function automatic void apply_fill(input step_t st);
    int x_len;
    int y_len;
    x_len = clipped_span(st.x, st.w, `FB_WIDTH);
    y_len = clipped_span(st.y, st.h, `FB_HEIGHT);
    for (int yy = 0; yy < y_len; yy++) begin
      for (int xx = 0; xx < x_len; xx++) begin
        frame_model[(st.y + yy) * `FB_WIDTH + st.x + xx] = color_word(st.color);
      end
    end
  endfunction

  // pipelined read, data for address a shows one clock later
  task automatic compare_frame();
    rd_addr = '0;
    for (int a = 0; a < FRAME_WORDS; a++) begin
      @(posedge clk);
      #10;
      check_count++;
      if (rd_data !== frame_model[a]) begin
        $display("Error: rd_data at address %03h: expected %04h, got %04h",
                 a, frame_model[a], rd_data);
        error_count++;
      end
      if (a < FRAME_WORDS - 1) begin
        rd_addr = fb_addr_t'(a + 1);
      end
    end
  endtask

  task automatic run_fill(input step_t st);
    int pixels;
    int writes_before;
    int cycles;
    int limit;
    pixels = clipped_span(st.x, st.w, `FB_WIDTH) * clipped_span(st.y, st.h, `FB_HEIGHT);
    limit = pixels * 40 + 100;
    stall_density = st.density;
    writes_before = write_total;
    cmd_x = coord_t'(st.x);
    cmd_y = coord_t'(st.y);
    cmd_w = coord_t'(st.w);
    cmd_h = coord_t'(st.h);
    cmd_color = color_t'(st.color);
    cmd_valid = 1'b1;
    @(posedge clk);
    #10;
    cmd_valid = 1'b0;
    check_count++;
    if (busy !== 1'b1) begin
      $display("Error: busy after command: expected %h, got %h", 1'b1, busy);
      error_count++;
    end
    cycles = 0;
    while (busy === 1'b1 && cycles < limit) begin
      @(posedge clk);
      #10;
      cycles++;
    end
    if (busy === 1'b1) begin
      $display("fill at %0d,%0d size %0dx%0d still busy after %0d cycles, stall density %0d/16",
               st.x, st.y, st.w, st.h, cycles, st.density);
      error_count++;
    end else if (pixels == 0 && cycles > 2) begin
      $display("fill at %0d,%0d clipped to nothing but kept busy high for %0d cycles",
               st.x, st.y, cycles);
      error_count++;
    end
    if (write_total - writes_before != pixels) begin
      $display("Error: write count: expected %h, got %h", pixels, write_total - writes_before);
      error_count++;
    end
    apply_fill(st);
    compare_frame();
  endtask

  task automatic check_word(input step_t st);
    rd_addr = fb_addr_t'(st.addr);
    @(posedge clk);
    #10;
    check_count++;
    if (rd_data !== fb_data_t'(st.word)) begin
      $display("Error: rd_data at address %03h: expected %04h, got %04h",
               st.addr, fb_data_t'(st.word), rd_data);
      error_count++;
    end
    if (frame_model[st.addr] !== fb_data_t'(st.word)) begin
      $display("pattern file expects %04h at address %03h but the frame model holds %04h",
               st.word, st.addr, frame_model[st.addr]);
      error_count++;
    end
  endtask

  initial begin
    int               fd;
    int               code;
    int               total_pix;
    int               fills;
    int               reads;
    int               v [6];
    string            kind;
    logic [8*256-1:0] skip_line;
    step_t            st;
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd_x = '0;
    cmd_y = '0;
    cmd_w = '0;
    cmd_h = '0;
    cmd_color = '0;
    rd_addr = '0;
    stall_density = 0;
    error_count = 0;
    check_count = 0;
    budget_cycles = 0;
    total_pix = 0;
    fills = 0;
    reads = 0;
    for (int a = 0; a < FRAME_WORDS; a++) begin
      frame_model[a] = '0;
    end

    fd = $fopen("tests/fb_fill_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/fb_fill_patterns.txt");
      error_count++;
    end else begin
      while (1) begin
        code = $fscanf(fd, "%s", kind);
        if (code != 1) begin
          break;
        end
        st = '0;
        if (kind.substr(0, 0) == "#") begin
          code = $fgets(skip_line, fd);
        end else if (kind == "fill") begin
          code = $fscanf(fd, "%d %d %d %d %h %d", v[0], v[1], v[2], v[3], v[4], v[5]);
          if (code != 6) begin
            $display("fill line in the pattern file is malformed");
            error_count++;
          end
          st.is_fill = 1;
          st.x = v[0];
          st.y = v[1];
          st.w = v[2];
          st.h = v[3];
          st.color = v[4];
          st.density = v[5];
          steps.push_back(st);
          total_pix += clipped_span(v[0], v[2], `FB_WIDTH) * clipped_span(v[1], v[3], `FB_HEIGHT);
          fills++;
        end else if (kind == "check") begin
          code = $fscanf(fd, "%h %h", v[0], v[1]);
          if (code != 2) begin
            $display("check line in the pattern file is malformed");
            error_count++;
          end
          st.addr = v[0];
          st.word = v[1];
          steps.push_back(st);
          reads++;
        end else begin
          $display("unknown line kind %s in the pattern file", kind);
          error_count++;
        end
      end
      $fclose(fd);
    end
    budget_cycles = total_pix * 40 + fills * (FRAME_WORDS + 100) + reads * 4 + 2000;

    repeat (16) @(posedge clk);
    #10;
    reset = 1'b0;
    @(posedge clk);
    #10;
    check_count++;
    if (busy !== 1'b0) begin
      $display("Error: busy after reset: expected %h, got %h", 1'b0, busy);
      error_count++;
    end

    foreach (steps[i]) begin
      if (steps[i].is_fill != 0) begin
        run_fill(steps[i]);
      end else begin
        check_word(steps[i]);
      end
    end

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
